// File: rtl/csr_pkg.sv
package csr_pkg;

  // datapath widths
  localparam int CPU_WIDTH = 32;  // data and pc
  localparam int CSR_ADDRW = 12;  // csr address field of the instruction

  // machine mode csr addresses
  localparam logic [CSR_ADDRW-1:0] ADDR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDRW-1:0] ADDR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDRW-1:0] ADDR_MEPC    = 12'h341;
  localparam logic [CSR_ADDRW-1:0] ADDR_MCAUSE  = 12'h342;

  // mstatus fields we care about
  localparam int MSTATUS_MIE  = 3;  // global machine irq enable
  localparam int MSTATUS_MPIE = 7;  // mie saved on trap entry

  // mcause encodings
  localparam logic [CPU_WIDTH-1:0] CAUSE_ECALL_M   = 32'd11;
  localparam logic [CPU_WIDTH-1:0] CAUSE_EXT_IRQ_M = {1'b1, 31'd11};  // interrupt bit + code

  // decoded csr instruction from the core
  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,  // no csr access
    CSR_RW   = 2'd1,  // csrrw
    CSR_RS   = 2'd2,  // csrrs
    CSR_RC   = 2'd3   // csrrc
  } csr_op_e;

  // trap action picked in one cycle
  typedef enum logic [1:0] {
    TRAP_NONE  = 2'd0,
    TRAP_IRQ   = 2'd1,  // pending external interrupt taken
    TRAP_ECALL = 2'd2,  // environment call
    TRAP_MRET  = 2'd3   // return from trap
  } trap_kind_e;

endpackage

// File: rtl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                          i_clk,
  input  logic                          i_rst_n,

  // instruction read port
  input  logic                          i_ren,
  input  logic [csr_pkg::CSR_ADDRW-1:0] i_raddr,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_rdata,

  // instruction write port
  input  logic                          i_wen,
  input  logic [csr_pkg::CSR_ADDRW-1:0] i_waddr,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_wdata,

  // trap side writes, these win over the instruction port
  input  logic                          i_mepc_wen,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_mepc_wdata,
  input  logic                          i_mcause_wen,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_mcause_wdata,
  input  logic                          i_mstatus_wen,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_mstatus_wdata,

  // live values for the trap controller
  output logic [csr_pkg::CPU_WIDTH-1:0] o_mtvec,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_mstatus,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_mepc
);

  logic [csr_pkg::CPU_WIDTH-1:0] mstatus;  // machine status
  logic [csr_pkg::CPU_WIDTH-1:0] mtvec;    // trap handler base, direct mode only
  logic [csr_pkg::CPU_WIDTH-1:0] mepc;     // pc of the trapped instruction
  logic [csr_pkg::CPU_WIDTH-1:0] mcause;   // why we trapped

  // address match of the instruction write, one per register
  logic wsel_mstatus;
  logic wsel_mtvec;
  logic wsel_mepc;
  logic wsel_mcause;

  assign wsel_mstatus = i_wen & (i_waddr == csr_pkg::ADDR_MSTATUS);
  assign wsel_mtvec   = i_wen & (i_waddr == csr_pkg::ADDR_MTVEC);
  assign wsel_mepc    = i_wen & (i_waddr == csr_pkg::ADDR_MEPC);
  assign wsel_mcause  = i_wen & (i_waddr == csr_pkg::ADDR_MCAUSE);
  // unknown addresses match nothing, so the write is dropped

  // read mux, zero when idle or address unknown
  always_comb begin
    o_rdata = '0;
    if (i_ren) begin
      case (i_raddr)
        csr_pkg::ADDR_MSTATUS: o_rdata = mstatus;
        csr_pkg::ADDR_MTVEC:   o_rdata = mtvec;
        csr_pkg::ADDR_MEPC:    o_rdata = mepc;
        csr_pkg::ADDR_MCAUSE:  o_rdata = mcause;
        default:               o_rdata = '0;
      endcase
    end
  end

  // per register write priority, trap port first
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_mstatus_wen) begin
        mstatus <= i_mstatus_wdata;  // trap entry or mret
      end else if (wsel_mstatus) begin
        mstatus <= i_wdata;
      end

      if (wsel_mtvec) begin
        mtvec <= i_wdata;  // no trap port
      end

      if (i_mepc_wen) begin
        mepc <= i_mepc_wdata;
      end else if (wsel_mepc) begin
        mepc <= i_wdata;
      end

      if (i_mcause_wen) begin
        mcause <= i_mcause_wdata;
      end else if (wsel_mcause) begin
        mcause <= i_wdata;
      end
    end
  end

  assign o_mtvec   = mtvec;
  assign o_mstatus = mstatus;
  assign o_mepc    = mepc;

endmodule

// File: rtl/csr_exec.sv
`timescale 1ns/1ps

module csr_exec (
  // decoded instruction from the core
  input  csr_pkg::csr_op_e              i_csr_op,
  input  logic [csr_pkg::CSR_ADDRW-1:0] i_csr_addr,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_rs1_data,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_rd_data,   // old csr value for rd

  // register file read port
  output logic                          o_ren,
  output logic [csr_pkg::CSR_ADDRW-1:0] o_raddr,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_rdata,

  // register file write port
  output logic                          o_wen,
  output logic [csr_pkg::CSR_ADDRW-1:0] o_waddr,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_wdata
);

  logic csr_active;  // any of the three csr instructions

  assign csr_active = (i_csr_op != csr_pkg::CSR_NONE);

  // read the old value in the same cycle
  assign o_ren   = csr_active;
  assign o_raddr = i_csr_addr;

  // write back lands at the next edge
  assign o_wen   = csr_active;  // single cycle strobe, op is held one cycle
  assign o_waddr = i_csr_addr;

  // new value from the old one and rs1
  always_comb begin
    case (i_csr_op)
      csr_pkg::CSR_RW: o_wdata = i_rs1_data;             // plain swap
      csr_pkg::CSR_RS: o_wdata = i_rdata | i_rs1_data;   // set bits
      csr_pkg::CSR_RC: o_wdata = i_rdata & ~i_rs1_data;  // clear bits
      default:         o_wdata = i_rdata;                // no write anyway
    endcase
  end

  // rd always sees the value from before the write
  // reads as zero when no op, the file mux does that
  assign o_rd_data = i_rdata;

endmodule

// File: rtl/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
  input  logic                          i_clk,
  input  logic                          i_rst_n,

  // core side requests
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_pc,     // pc of the current instruction
  input  logic                          i_ecall,
  input  logic                          i_mret,
  input  logic                          i_irq,    // one cycle pulse

  // live csr values
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_mtvec,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_mepc,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_mstatus,

  // trap writes into the csr file
  output logic                          o_mepc_wen,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_mepc_wdata,
  output logic                          o_mcause_wen,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_mcause_wdata,
  output logic                          o_mstatus_wen,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_mstatus_wdata,

  // pc redirect to the core
  output logic                          o_redirect,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_redirect_pc
);

  logic                 irq_pend;   // interrupt seen, not yet taken
  logic                 mie;
  logic                 take_trap;  // ecall or irq entry
  csr_pkg::trap_kind_e  trap_kind;

  assign mie = i_mstatus[csr_pkg::MSTATUS_MIE];

  // priority ecall > mret > pending irq
  always_comb begin
    trap_kind = csr_pkg::TRAP_NONE;
    if (i_ecall) begin
      trap_kind = csr_pkg::TRAP_ECALL;
    end else if (i_mret) begin
      trap_kind = csr_pkg::TRAP_MRET;
    end else if (irq_pend && mie) begin
      trap_kind = csr_pkg::TRAP_IRQ;
    end
  end

  // pending flag, a fresh pulse re-arms it even while one is taken
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      irq_pend <= 1'b0;
    end else if (i_irq) begin
      irq_pend <= 1'b1;
    end else if (trap_kind == csr_pkg::TRAP_IRQ) begin
      irq_pend <= 1'b0;  // consumed
    end
  end

  assign take_trap = (trap_kind == csr_pkg::TRAP_ECALL) | (trap_kind == csr_pkg::TRAP_IRQ);

  // mepc and mcause only move on trap entry
  assign o_mepc_wen     = take_trap;
  assign o_mepc_wdata   = i_pc;
  assign o_mcause_wen   = take_trap;
  assign o_mcause_wdata = (trap_kind == csr_pkg::TRAP_IRQ) ? csr_pkg::CAUSE_EXT_IRQ_M
                                                           : csr_pkg::CAUSE_ECALL_M;

  // mstatus stack of mie/mpie
  always_comb begin
    o_mstatus_wdata = i_mstatus;  // other bits untouched
    if (take_trap) begin
      o_mstatus_wdata[csr_pkg::MSTATUS_MPIE] = mie;
      o_mstatus_wdata[csr_pkg::MSTATUS_MIE]  = 1'b0;  // handler runs masked
    end else if (trap_kind == csr_pkg::TRAP_MRET) begin
      o_mstatus_wdata[csr_pkg::MSTATUS_MIE]  = i_mstatus[csr_pkg::MSTATUS_MPIE];
      o_mstatus_wdata[csr_pkg::MSTATUS_MPIE] = 1'b1;
    end
  end
  assign o_mstatus_wen = take_trap | (trap_kind == csr_pkg::TRAP_MRET);

  // redirect is valid in the request cycle
  assign o_redirect    = (trap_kind != csr_pkg::TRAP_NONE);
  assign o_redirect_pc = (trap_kind == csr_pkg::TRAP_MRET) ? i_mepc : i_mtvec;

endmodule

// File: rtl/csr_top.sv
`timescale 1ns/1ps

module csr_top (
  input  logic                          i_clk,
  input  logic                          i_rst_n,

  // csr instruction
  input  csr_pkg::csr_op_e              i_csr_op,
  input  logic [csr_pkg::CSR_ADDRW-1:0] i_csr_addr,
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_rs1_data,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_rd_data,

  // trap requests and redirect
  input  logic [csr_pkg::CPU_WIDTH-1:0] i_pc,
  input  logic                          i_ecall,
  input  logic                          i_mret,
  input  logic                          i_irq,
  output logic                          o_redirect,
  output logic [csr_pkg::CPU_WIDTH-1:0] o_redirect_pc
);

  // executor <-> csr file
  logic                          ren;
  logic [csr_pkg::CSR_ADDRW-1:0] raddr;
  logic [csr_pkg::CPU_WIDTH-1:0] rdata;
  logic                          wen;
  logic [csr_pkg::CSR_ADDRW-1:0] waddr;
  logic [csr_pkg::CPU_WIDTH-1:0] wdata;

  // trap controller <-> csr file
  logic                          mepc_wen;
  logic [csr_pkg::CPU_WIDTH-1:0] mepc_wdata;
  logic                          mcause_wen;
  logic [csr_pkg::CPU_WIDTH-1:0] mcause_wdata;
  logic                          mstatus_wen;
  logic [csr_pkg::CPU_WIDTH-1:0] mstatus_wdata;
  logic [csr_pkg::CPU_WIDTH-1:0] mtvec;
  logic [csr_pkg::CPU_WIDTH-1:0] mstatus;
  logic [csr_pkg::CPU_WIDTH-1:0] mepc;

  csr_exec u_exec (
    .i_csr_op   (i_csr_op),
    .i_csr_addr (i_csr_addr),
    .i_rs1_data (i_rs1_data),
    .o_rd_data  (o_rd_data),
    .o_ren      (ren),
    .o_raddr    (raddr),
    .i_rdata    (rdata),
    .o_wen      (wen),
    .o_waddr    (waddr),
    .o_wdata    (wdata)
  );

  trap_ctrl u_trap (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_pc            (i_pc),
    .i_ecall         (i_ecall),
    .i_mret          (i_mret),
    .i_irq           (i_irq),
    .i_mtvec         (mtvec),
    .i_mepc          (mepc),
    .i_mstatus       (mstatus),
    .o_mepc_wen      (mepc_wen),
    .o_mepc_wdata    (mepc_wdata),
    .o_mcause_wen    (mcause_wen),
    .o_mcause_wdata  (mcause_wdata),
    .o_mstatus_wen   (mstatus_wen),
    .o_mstatus_wdata (mstatus_wdata),
    .o_redirect      (o_redirect),
    .o_redirect_pc   (o_redirect_pc)
  );

  // trap writes beat instruction writes in here
  csr_file u_file (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_ren           (ren),
    .i_raddr         (raddr),
    .o_rdata         (rdata),
    .i_wen           (wen),
    .i_waddr         (waddr),
    .i_wdata         (wdata),
    .i_mepc_wen      (mepc_wen),
    .i_mepc_wdata    (mepc_wdata),
    .i_mcause_wen    (mcause_wen),
    .i_mcause_wdata  (mcause_wdata),
    .i_mstatus_wen   (mstatus_wen),
    .i_mstatus_wdata (mstatus_wdata),
    .o_mtvec         (mtvec),
    .o_mstatus       (mstatus),
    .o_mepc          (mepc)
  );

endmodule

// File: dv/csr_assertions.sv
`timescale 1ns/1ps

module csr_assertions (
  input logic                          i_clk,
  input logic                          i_rst_n,
  input logic                          i_ecall,
  input logic                          i_mret,
  input logic                          i_redirect,
  input logic                          i_mepc_wen,    // trap entry strobes
  input logic                          i_mcause_wen,
  input logic [csr_pkg::CPU_WIDTH-1:0] i_mstatus
);

  logic trap_entry;  // ecall, or a redirect that is not an mret

  assign trap_entry = i_ecall | (i_redirect & ~i_mret);

  // core must never be redirected out of reset
  redirect_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_redirect)
    else $error("redirect raised while reset is held");

  // trap entry writes mepc and mcause as a pair, and only on entry
  trap_strobes_paired: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (trap_entry || i_mepc_wen || i_mcause_wen) |->
      (trap_entry && i_mepc_wen && i_mcause_wen))
    else $error("mepc and mcause strobes not raised together on trap entry");

  // handler starts with interrupts masked
  mie_clear_after_trap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    trap_entry |=> !i_mstatus[csr_pkg::MSTATUS_MIE])
    else $error("mstatus.MIE still set after trap entry");

endmodule

bind csr_top csr_assertions u_assertions (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_ecall      (i_ecall),
  .i_mret       (i_mret),
  .i_redirect   (o_redirect),
  .i_mepc_wen   (mepc_wen),
  .i_mcause_wen (mcause_wen),
  .i_mstatus    (mstatus)
);

// File: dv/tb_csr_top.sv
`timescale 1ns/1ps

module tb_csr_top;

  localparam int RESET_CYCLES = 10;
  localparam int SLACK_CYCLES = 20;  // margin on top of vectors and reset

  // one line of the vector file
  typedef struct {
    logic [31:0] test;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] rs1;
    logic [31:0] pc;
    logic [31:0] ecall;
    logic [31:0] mret;
    logic [31:0] irq;
    logic [31:0] exp_rd;
    logic [31:0] exp_redirect;
    logic [31:0] exp_redirect_pc;
  } vec_t;

  logic                          i_clk;
  logic                          i_rst_n;
  csr_pkg::csr_op_e              i_csr_op;
  logic [csr_pkg::CSR_ADDRW-1:0] i_csr_addr;
  logic [csr_pkg::CPU_WIDTH-1:0] i_rs1_data;
  logic [csr_pkg::CPU_WIDTH-1:0] o_rd_data;
  logic [csr_pkg::CPU_WIDTH-1:0] i_pc;
  logic                          i_ecall;
  logic                          i_mret;
  logic                          i_irq;
  logic                          o_redirect;
  logic [csr_pkg::CPU_WIDTH-1:0] o_redirect_pc;

  vec_t vecs[$];
  int   errors;
  int   test_errors;  // errors in the test that is running
  int   tests_run;
  int   cycles;
  int   cycle_limit;  // zero until the vectors are loaded

  csr_top UUT (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_csr_op      (i_csr_op),
    .i_csr_addr    (i_csr_addr),
    .i_rs1_data    (i_rs1_data),
    .o_rd_data     (o_rd_data),
    .i_pc          (i_pc),
    .i_ecall       (i_ecall),
    .i_mret        (i_mret),
    .i_irq         (i_irq),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  always #5 i_clk = ~i_clk;  // 10 ns period

  // run length guard
  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // read vectors, lines that do not hold 11 hex fields are skipped
  task automatic load_vectors(output bit ok);
    int    fd;
    int    n;
    string line;
    vec_t  v;
    fd = $fopen("dv/csr_input.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v.test, v.op, v.addr,
                      v.rs1, v.pc, v.ecall, v.mret, v.irq, v.exp_rd, v.exp_redirect,
                      v.exp_redirect_pc);
          if (n == 11) begin
            vecs.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive(input vec_t v);
    i_csr_op   = csr_pkg::csr_op_e'(v.op[1:0]);
    i_csr_addr = v.addr[csr_pkg::CSR_ADDRW-1:0];
    i_rs1_data = v.rs1;
    i_pc       = v.pc;
    i_ecall    = v.ecall[0];
    i_mret     = v.mret[0];
    i_irq      = v.irq[0];  // one line = one cycle pulse
  endtask

  task automatic compare(input vec_t v);
    string tag;
    tag = $sformatf("test %0d op %0d csr %h", v.test, v.op, v.addr[11:0]);
    check(o_rd_data, v.exp_rd, {tag, " rd"});
    check({31'd0, o_redirect}, v.exp_redirect, {tag, " redirect"});
    if (v.exp_redirect[0]) begin
      check(o_redirect_pc, v.exp_redirect_pc, {tag, " redirect pc"});  // target only matters here
    end
  endtask

  task automatic report_test(input logic [31:0] num);
    $display("test %0d %s with %0d errors", num, (test_errors == 0) ? "passed" : "failed",
             test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  initial begin
    bit ok;
    bit last;
    i_clk       = 1'b0;
    i_rst_n     = 1'b0;
    i_csr_op    = csr_pkg::CSR_NONE;
    i_csr_addr  = '0;
    i_rs1_data  = '0;
    i_pc        = '0;
    i_ecall     = 1'b0;
    i_mret      = 1'b0;
    i_irq       = 1'b0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    cycles      = 0;
    cycle_limit = 0;
    load_vectors(ok);
    if (!ok || vecs.size() == 0) begin
      $display("cannot read any vectors from dv/csr_input.txt");
      $display("Finished with errors");
      $finish;
    end else begin
      cycle_limit = vecs.size() + RESET_CYCLES + SLACK_CYCLES;
      repeat (RESET_CYCLES) @(posedge i_clk);
      #1;
      i_rst_n = 1'b1;
      foreach (vecs[i]) begin
        drive(vecs[i]);
        #8;  // just before the next edge
        compare(vecs[i]);
        last = (i == vecs.size() - 1);
        if (last) begin
          report_test(vecs[i].test);
        end else if (vecs[i + 1].test != vecs[i].test) begin
          report_test(vecs[i].test);
        end
        @(posedge i_clk);
        #1;
      end
      drive('{default: '0});  // back to idle
      $display("%0d tests run, %0d errors", tests_run, errors);
      if (errors == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
      $finish;
    end
  end

endmodule

// File: dv/csr_input.txt
// test op addr rs1 pc ecall mret irq exp_rd exp_redirect exp_redirect_pc, all hex
// op 0 none 1 csrrw 2 csrrs 3 csrrc, redirect pc only checked when redirect is 1
// test 1 reset values and unknown address
1 0 000 00000000 00000000 0 0 0 00000000 0 00000000
1 2 300 00000000 00000000 0 0 0 00000000 0 00000000
1 2 305 00000000 00000000 0 0 0 00000000 0 00000000
1 2 341 00000000 00000000 0 0 0 00000000 0 00000000
1 2 342 00000000 00000000 0 0 0 00000000 0 00000000
1 1 7c0 deadbeef 00000000 0 0 0 00000000 0 00000000
1 2 7c0 00000000 00000000 0 0 0 00000000 0 00000000
// test 2 csrrw on every csr
2 1 305 00000100 00000000 0 0 0 00000000 0 00000000
2 1 305 00000200 00000000 0 0 0 00000100 0 00000000
2 1 341 11111110 00000000 0 0 0 00000000 0 00000000
2 1 342 12345678 00000000 0 0 0 00000000 0 00000000
2 1 300 00000080 00000000 0 0 0 00000000 0 00000000
2 2 341 00000000 00000000 0 0 0 11111110 0 00000000
2 2 342 00000000 00000000 0 0 0 12345678 0 00000000
2 2 300 00000000 00000000 0 0 0 00000080 0 00000000
2 2 305 00000000 00000000 0 0 0 00000200 0 00000000
// test 3 set and clear bits
3 2 300 00000008 00000000 0 0 0 00000080 0 00000000
3 3 300 00000080 00000000 0 0 0 00000088 0 00000000
3 2 342 0000000f 00000000 0 0 0 12345678 0 00000000
3 3 342 12340000 00000000 0 0 0 1234567f 0 00000000
3 2 342 00000000 00000000 0 0 0 0000567f 0 00000000
3 3 300 00000008 00000000 0 0 0 00000008 0 00000000
// test 4 ecall
4 2 300 00000008 00000000 0 0 0 00000000 0 00000000
4 0 000 00000000 00001000 1 0 0 00000000 1 00000200
4 2 341 00000000 00000000 0 0 0 00001000 0 00000000
4 2 342 00000000 00000000 0 0 0 0000000b 0 00000000
4 2 300 00000000 00000000 0 0 0 00000080 0 00000000
// test 5 mret, then an interrupt held pending until MIE is set
5 0 000 00000000 00000204 0 1 0 00000000 1 00001000
5 2 300 00000000 00000000 0 0 0 00000088 0 00000000
5 3 300 00000008 00000000 0 0 0 00000088 0 00000000
5 0 000 00000000 00001004 0 0 1 00000000 0 00000000
5 0 000 00000000 00001008 0 0 0 00000000 0 00000000
5 2 300 00000008 0000100c 0 0 0 00000080 0 00000000
5 0 000 00000000 00001010 0 0 0 00000000 1 00000200
5 2 342 00000000 00000000 0 0 0 8000000b 0 00000000
5 2 341 00000000 00000000 0 0 0 00001010 0 00000000
5 2 300 00000000 00000000 0 0 0 00000080 0 00000000
// test 6 csrrw to mepc in the ecall cycle
6 1 341 aaaaaaa0 00002000 1 0 0 00001010 1 00000200
6 2 341 00000000 00000000 0 0 0 00002000 0 00000000
6 2 300 00000000 00000000 0 0 0 00000000 0 00000000
6 2 342 00000000 00000000 0 0 0 0000000b 0 00000000

// File: list.f
rtl/csr_pkg.sv
rtl/csr_file.sv
rtl/csr_exec.sv
rtl/trap_ctrl.sv
rtl/csr_top.sv
dv/csr_assertions.sv
dv/tb_csr_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_csr_top \
  -f list.f -o sim_csr &&
{ out="$(./obj_dir/sim_csr 2>&1)"; printf '%s\n' "$out"; } &&
printf '%s\n' "$out" | grep -qx "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
